//--- hdl/eth_stream_pkg.sv
package eth_stream_pkg;

	// ------------------------------
	// sizes
	localparam int DATA_W = 32; // sample and bus word
	localparam int BLOCK_WORDS = 16; // payload words per frame
	localparam int BLOCK_BYTES = 64; // goes out in the length field
	localparam int HDR_WORDS = 8;
	localparam int FIFO_DEPTH = 64; // per channel
	localparam int FILL_W = 7;
	localparam int SLOTS = 2; // payload buffer slots
	localparam int RESTART_CYCLES = 1000; // hold-off after restart

	localparam int WORD_AW = $clog2(BLOCK_WORDS); // word index inside a block
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	localparam int SLOT_W = $clog2(SLOTS);
	localparam int SLOT_CNT_W = $clog2(SLOTS + 1); // counts 0..SLOTS
	localparam int FRAME_WORDS = HDR_WORDS + BLOCK_WORDS + 1; // header, payload, checksum
	localparam int BEAT_W = $clog2(FRAME_WORDS);
	localparam int RESTART_W = $clog2(RESTART_CYCLES + 1);

	// ------------------------------
	// spi register map
	localparam int SPI_ADDR_W = 8;
	localparam int SPI_DATA_W = 64;
	localparam int SPI_XFER_BITS = SPI_ADDR_W + SPI_DATA_W; // address then data
	localparam int SPI_CNT_W = $clog2(SPI_XFER_BITS + 1);
	localparam logic [SPI_ADDR_W-1:0] ADDR_CONTROL = 8'd15; // bit 0 is stream_off
	localparam logic [SPI_ADDR_W-1:0] ADDR_IP = 8'd21;
	localparam logic [SPI_ADDR_W-1:0] ADDR_PORT = 8'd22;
	localparam logic [SPI_ADDR_W-1:0] ADDR_MAC_MY = 8'd23;
	localparam logic [SPI_ADDR_W-1:0] ADDR_MAC_DEST = 8'd24;

	// ------------------------------
	// spi data word, read by address
	typedef struct packed {
		logic [31:0] ip_my;
		logic [31:0] ip_dest;
	} cfg_ip_t;

	typedef struct packed {
		logic [31:0] unused;
		logic [15:0] port_my;
		logic [15:0] port_dest; // control port, data goes to +1
	} cfg_port_t;

	typedef struct packed {
		logic [15:0] unused;
		logic [47:0] mac;
	} cfg_mac_t;

	typedef union packed {
		cfg_ip_t ip;
		cfg_port_t port;
		cfg_mac_t mac;
	} cfg_payload_u;

	typedef struct packed {
		logic [31:0] ip_my;
		logic [31:0] ip_dest;
		logic [15:0] port_my;
		logic [15:0] port_dest;
		logic [47:0] mac_my;
		logic [47:0] mac_dest;
		logic stream_off; // 1 stops and flushes the stream
	} stream_cfg_t;

	// ------------------------------
	// datapath words
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic wr;
	} sample_in_t;

	typedef struct packed {
		logic en;
		logic [SLOT_W-1:0] slot;
		logic [WORD_AW-1:0] addr;
		logic [DATA_W-1:0] data;
	} buf_wr_t;

	typedef struct packed {
		logic [SLOT_W-1:0] slot;
		logic [7:0] channel;
		logic [15:0] length; // bytes
		logic [DATA_W-1:0] checksum; // payload sum mod 2^32
		logic [31:0] stamp; // {interval, packet count}
	} block_desc_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic sop;
		logic eop;
		logic wren;
	} tx_word_t;

endpackage

//--- hdl/spi_config_regs.sv
`timescale 1ns/10ps

module spi_config_regs (
	input logic clk_125,
	input logic rst_crc,
	input logic spi_sclk,
	input logic spi_mosi,
	input logic spi_cs_n,
	output eth_stream_pkg::stream_cfg_t cfg
);

	logic [2:0] sclk_q; // sync plus edge stage
	logic [1:0] mosi_q; // aligned with sclk_q[1]
	logic [2:0] cs_q;
	logic sclk_rise;
	logic cs_rise;
	logic cs_active;
	logic [eth_stream_pkg::SPI_XFER_BITS-1:0] shift_q;
	logic [eth_stream_pkg::SPI_CNT_W-1:0] bit_cnt;
	logic [eth_stream_pkg::SPI_ADDR_W-1:0] addr;
	eth_stream_pkg::cfg_payload_u payload;
	logic xfer_ok;

	// ------------------------------
	// bring the spi lines into clk_125
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			sclk_q <= '0;
			mosi_q <= '0;
			cs_q <= '1; // idle high, no false rise
		end
		else
		begin
			sclk_q <= {sclk_q[1:0], spi_sclk};
			mosi_q <= {mosi_q[0], spi_mosi};
			cs_q <= {cs_q[1:0], spi_cs_n};
		end
	end

	assign sclk_rise = sclk_q[1] && !sclk_q[2];
	assign cs_rise = cs_q[1] && !cs_q[2]; // end of transfer
	assign cs_active = !cs_q[1];

	// ------------------------------
	// shifter, msb first
	always_ff @(posedge clk_125)
	begin
		if (cs_active && sclk_rise)
			shift_q <= {shift_q[eth_stream_pkg::SPI_XFER_BITS-2:0], mosi_q[1]};
	end

	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
			bit_cnt <= '0;
		else if (!cs_active)
			bit_cnt <= '0; // cleared between transfers
		else if (sclk_rise && bit_cnt != '1)
			bit_cnt <= bit_cnt + 1'b1; // saturates, long transfers never match
	end

	assign addr = shift_q[eth_stream_pkg::SPI_XFER_BITS-1:eth_stream_pkg::SPI_DATA_W];
	assign payload = shift_q[eth_stream_pkg::SPI_DATA_W-1:0];
	assign xfer_ok = cs_rise
		&& (bit_cnt == eth_stream_pkg::SPI_CNT_W'(eth_stream_pkg::SPI_XFER_BITS));

	// ------------------------------
	// register decode on cs_n rise
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			cfg <= '0;
			cfg.stream_off <= 1'b1; // stream stays off until enabled
		end
		else if (xfer_ok)
		begin
			case (addr)
				eth_stream_pkg::ADDR_CONTROL: cfg.stream_off <= shift_q[0];
				eth_stream_pkg::ADDR_IP:
				begin
					cfg.ip_my <= payload.ip.ip_my;
					cfg.ip_dest <= payload.ip.ip_dest;
				end
				eth_stream_pkg::ADDR_PORT:
				begin
					cfg.port_my <= payload.port.port_my;
					cfg.port_dest <= payload.port.port_dest;
				end
				eth_stream_pkg::ADDR_MAC_MY: cfg.mac_my <= payload.mac.mac;
				eth_stream_pkg::ADDR_MAC_DEST: cfg.mac_dest <= payload.mac.mac;
				default: ; // unknown address ignored
			endcase
		end
	end

endmodule

//--- hdl/channel_fifo.sv
`timescale 1ns/10ps

module channel_fifo (
	input logic clk_125,
	input logic rst_crc,
	input logic flush,
	input eth_stream_pkg::sample_in_t wr_in,
	input logic rd,
	output logic [eth_stream_pkg::DATA_W-1:0] data,
	output logic [eth_stream_pkg::FILL_W-1:0] fill
);

	logic [eth_stream_pkg::DATA_W-1:0] mem [eth_stream_pkg::FIFO_DEPTH];
	logic [eth_stream_pkg::FIFO_AW-1:0] wr_ptr;
	logic [eth_stream_pkg::FIFO_AW-1:0] rd_ptr;
	logic wr_ok;
	logic rd_ok;

	assign wr_ok = wr_in.wr && !flush
		&& (fill != eth_stream_pkg::FILL_W'(eth_stream_pkg::FIFO_DEPTH)); // drop when full
	assign rd_ok = rd && (fill != '0);

	always_ff @(posedge clk_125)
	begin
		if (wr_ok)
			mem[wr_ptr] <= wr_in.data;
	end

	// ------------------------------
	// pointers and fill count
	always_ff @(posedge clk_125)
	begin
		if (rst_crc || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end
		else
		begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ; // both or neither
			endcase
		end
	end

	assign data = mem[rd_ptr]; // head word, valid while fill > 0

	// assembler only reads words it has counted
	a_no_underflow: assert property (@(posedge clk_125) disable iff (rst_crc)
		!(rd && fill == '0))
		else $error("channel_fifo read while empty");

endmodule

//--- hdl/block_assembler.sv
`timescale 1ns/10ps

module block_assembler (
	input logic clk_125,
	input logic rst_crc,
	input eth_stream_pkg::stream_cfg_t cfg,
	input logic time_clr,
	input logic [15:0] numb_inter,
	input logic [eth_stream_pkg::FILL_W-1:0] fill0,
	input logic [eth_stream_pkg::FILL_W-1:0] fill1,
	input logic [eth_stream_pkg::DATA_W-1:0] data0,
	input logic [eth_stream_pkg::DATA_W-1:0] data1,
	output logic rd0,
	output logic rd1,
	output eth_stream_pkg::buf_wr_t buf_wr,
	output eth_stream_pkg::block_desc_t desc,
	output logic desc_valid,
	input logic frame_done
);

	typedef enum logic [1:0] {S_IDLE, S_READ, S_DONE} state_t;

	state_t state;
	logic [eth_stream_pkg::RESTART_W-1:0] wait_cnt; // hold-off after restart
	logic go;
	logic restart;
	logic [eth_stream_pkg::WORD_AW-1:0] word_cnt;
	logic sel; // channel being read
	logic prefer; // channel served on a tie
	logic pick;
	logic rdy0;
	logic rdy1;
	logic can_start;
	logic reading;
	logic [eth_stream_pkg::DATA_W-1:0] rd_data;
	logic [eth_stream_pkg::DATA_W-1:0] csum;
	logic [eth_stream_pkg::SLOT_W-1:0] wr_slot;
	logic [eth_stream_pkg::SLOT_CNT_W-1:0] slots_used;
	logic [15:0] pkt_cnt;

	assign restart = time_clr || cfg.stream_off;
	assign go = wait_cnt == eth_stream_pkg::RESTART_W'(eth_stream_pkg::RESTART_CYCLES);
	assign rdy0 = fill0 >= eth_stream_pkg::FILL_W'(eth_stream_pkg::BLOCK_WORDS);
	assign rdy1 = fill1 >= eth_stream_pkg::FILL_W'(eth_stream_pkg::BLOCK_WORDS);
	assign pick = (rdy0 && rdy1) ? prefer : rdy1; // 1 means channel 1
	assign can_start = (state == S_IDLE) && go && !restart && !desc_valid
		&& (slots_used < eth_stream_pkg::SLOT_CNT_W'(eth_stream_pkg::SLOTS))
		&& (rdy0 || rdy1);
	assign reading = state == S_READ;
	assign rd0 = reading && !sel;
	assign rd1 = reading && sel;
	assign rd_data = sel ? data1 : data0;

	// ------------------------------
	// restart hold-off
	always_ff @(posedge clk_125)
	begin
		if (rst_crc || restart)
			wait_cnt <= '0;
		else if (!go)
			wait_cnt <= wait_cnt + 1'b1;
	end

	// ------------------------------
	// block sequencer
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			state <= S_IDLE;
			word_cnt <= '0;
			sel <= 1'b0;
			prefer <= 1'b0; // channel 0 goes first
			wr_slot <= '0;
			desc_valid <= 1'b0;
		end
		else
		begin
			desc_valid <= 1'b0;
			if (cfg.stream_off)
				state <= S_IDLE; // abort, fifos are being flushed
			else
			begin
				case (state)
					S_IDLE:
					begin
						if (can_start)
						begin
							state <= S_READ;
							sel <= pick;
							prefer <= !pick; // alternate on ties
							word_cnt <= '0;
						end
					end
					S_READ:
					begin
						word_cnt <= word_cnt + 1'b1;
						if (word_cnt == eth_stream_pkg::WORD_AW'(eth_stream_pkg::BLOCK_WORDS - 1))
							state <= S_DONE;
					end
					S_DONE:
					begin
						desc_valid <= 1'b1; // one cycle after last buffer write
						wr_slot <= wr_slot + 1'b1; // framer frees slots in order
						state <= S_IDLE;
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	// ------------------------------
	// descriptor, checksum, buffer write
	always_ff @(posedge clk_125)
	begin
		if (can_start)
		begin
			desc.slot <= wr_slot;
			desc.channel <= {7'd0, pick};
			desc.length <= 16'(eth_stream_pkg::BLOCK_BYTES);
			desc.stamp <= {numb_inter, pkt_cnt};
			csum <= '0;
		end
		if (reading)
			csum <= csum + rd_data; // wraps mod 2^32
		if (state == S_DONE)
			desc.checksum <= csum;
		buf_wr.slot <= desc.slot;
		buf_wr.addr <= word_cnt;
		buf_wr.data <= rd_data;
	end

	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
			buf_wr.en <= 1'b0;
		else
			buf_wr.en <= reading;
	end

	// ------------------------------
	// packet count and slot usage
	always_ff @(posedge clk_125)
	begin
		if (rst_crc || time_clr)
			pkt_cnt <= '0;
		else if (can_start)
			pkt_cnt <= pkt_cnt + 1'b1;
	end

	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
			slots_used <= '0;
		else
		begin
			case ({desc_valid, frame_done})
				2'b10: slots_used <= slots_used + 1'b1;
				2'b01: slots_used <= slots_used - 1'b1;
				default: ;
			endcase
		end
	end

	a_one_reader: assert property (@(posedge clk_125) disable iff (rst_crc)
		!(rd0 && rd1))
		else $error("both channel fifos read at once");

	// framer must always have room for the new descriptor
	a_slot_free: assert property (@(posedge clk_125) disable iff (rst_crc)
		desc_valid |-> slots_used < eth_stream_pkg::SLOT_CNT_W'(eth_stream_pkg::SLOTS))
		else $error("descriptor issued with all slots in use");

endmodule

//--- hdl/stream_framer.sv
`timescale 1ns/10ps

module stream_framer (
	input logic clk_125,
	input logic rst_crc,
	input eth_stream_pkg::stream_cfg_t cfg,
	input eth_stream_pkg::buf_wr_t buf_wr,
	input eth_stream_pkg::block_desc_t desc,
	input logic desc_valid,
	input logic tx_rdy,
	output eth_stream_pkg::tx_word_t tx,
	output logic frame_done
);

	logic [eth_stream_pkg::DATA_W-1:0] ram [eth_stream_pkg::SLOTS * eth_stream_pkg::BLOCK_WORDS];
	eth_stream_pkg::block_desc_t q_desc; // one-entry queue
	logic q_valid;
	eth_stream_pkg::block_desc_t cur; // frame on the wire
	eth_stream_pkg::stream_cfg_t hdr; // header fields, taken at start
	logic busy;
	logic take;
	logic [eth_stream_pkg::BEAT_W-1:0] beat;
	logic [eth_stream_pkg::BEAT_W-1:0] pay_idx;
	logic last_beat;
	logic [eth_stream_pkg::DATA_W-1:0] word;

	always_ff @(posedge clk_125)
	begin
		if (buf_wr.en)
			ram[{buf_wr.slot, buf_wr.addr}] <= buf_wr.data;
	end

	assign take = !busy && q_valid;
	assign last_beat = beat == eth_stream_pkg::BEAT_W'(eth_stream_pkg::FRAME_WORDS - 1);
	assign pay_idx = beat - eth_stream_pkg::BEAT_W'(eth_stream_pkg::HDR_WORDS);

	// ------------------------------
	// descriptor queue
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
			q_valid <= 1'b0;
		else
		begin
			if (take)
				q_valid <= 1'b0;
			if (desc_valid)
				q_valid <= 1'b1; // refill wins over take
		end
	end

	always_ff @(posedge clk_125)
	begin
		if (desc_valid)
			q_desc <= desc;
		if (take)
		begin
			cur <= q_desc;
			hdr <= cfg;
		end
	end

	// ------------------------------
	// beat counter, steps on tx_rdy only
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			busy <= 1'b0;
			beat <= '0;
		end
		else if (take)
		begin
			busy <= 1'b1;
			beat <= '0;
		end
		else if (busy && tx_rdy)
		begin
			if (last_beat)
			begin
				busy <= 1'b0;
				beat <= '0;
			end
			else
				beat <= beat + 1'b1;
		end
	end

	always_comb
	begin
		word = ram[{cur.slot, pay_idx[eth_stream_pkg::WORD_AW-1:0]}]; // payload words 8..23
		case (beat)
			5'd0: word = hdr.mac_dest[47:16];
			5'd1: word = {hdr.mac_dest[15:0], hdr.mac_my[47:32]};
			5'd2: word = hdr.mac_my[31:0];
			5'd3: word = hdr.ip_my;
			5'd4: word = hdr.ip_dest;
			5'd5: word = {hdr.port_my, hdr.port_dest + 16'd1}; // data port is control + 1
			5'd6: word = cur.stamp;
			5'd7: word = {8'd0, cur.channel, cur.length};
			5'd24: word = cur.checksum;
			default: ;
		endcase
	end

	always_comb
	begin
		tx.data = word;
		tx.sop = busy && (beat == '0);
		tx.eop = busy && last_beat;
		tx.wren = busy && tx_rdy;
	end

	assign frame_done = tx.wren && last_beat;

	a_wren_rdy: assert property (@(posedge clk_125) disable iff (rst_crc)
		tx.wren |-> tx_rdy)
		else $error("beat sent without tx_rdy");

	// stalled word must not move, its slot is still counted in use
	a_hold: assert property (@(posedge clk_125) disable iff (rst_crc)
		busy && !tx_rdy |=> $stable(beat) && $stable(tx.data))
		else $error("word changed during back-pressure");

endmodule

//--- hdl/eth_stream_top.sv
`timescale 1ns/10ps

module eth_stream_top (
	input logic clk_125,
	input logic rst_crc,
	input logic spi_sclk,
	input logic spi_mosi,
	input logic spi_cs_n,
	input eth_stream_pkg::sample_in_t ch0,
	input eth_stream_pkg::sample_in_t ch1,
	input logic [15:0] numb_inter,
	input logic time_clr,
	input logic tx_rdy,
	output eth_stream_pkg::tx_word_t tx
);

	eth_stream_pkg::stream_cfg_t cfg;
	logic [eth_stream_pkg::DATA_W-1:0] data0;
	logic [eth_stream_pkg::DATA_W-1:0] data1;
	logic [eth_stream_pkg::FILL_W-1:0] fill0;
	logic [eth_stream_pkg::FILL_W-1:0] fill1;
	logic rd0;
	logic rd1;
	eth_stream_pkg::buf_wr_t buf_wr;
	eth_stream_pkg::block_desc_t desc;
	logic desc_valid;
	logic frame_done;

	// ------------------------------
	// input side
	spi_config_regs u_spi (
		.clk_125(clk_125), .rst_crc(rst_crc),
		.spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n),
		.cfg(cfg)
	);

	channel_fifo u_fifo0 (
		.clk_125(clk_125), .rst_crc(rst_crc), .flush(cfg.stream_off),
		.wr_in(ch0), .rd(rd0), .data(data0), .fill(fill0)
	);

	channel_fifo u_fifo1 (
		.clk_125(clk_125), .rst_crc(rst_crc), .flush(cfg.stream_off),
		.wr_in(ch1), .rd(rd1), .data(data1), .fill(fill1)
	);

	// ------------------------------
	// processing
	block_assembler u_asm (
		.clk_125(clk_125), .rst_crc(rst_crc), .cfg(cfg),
		.time_clr(time_clr), .numb_inter(numb_inter),
		.fill0(fill0), .fill1(fill1), .data0(data0), .data1(data1),
		.rd0(rd0), .rd1(rd1), .buf_wr(buf_wr), .desc(desc),
		.desc_valid(desc_valid), .frame_done(frame_done)
	);

	// ------------------------------
	// output side
	stream_framer u_framer (
		.clk_125(clk_125), .rst_crc(rst_crc), .cfg(cfg),
		.buf_wr(buf_wr), .desc(desc), .desc_valid(desc_valid),
		.tx_rdy(tx_rdy), .tx(tx), .frame_done(frame_done)
	);

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_125,
	output logic rst_crc
);

	initial
	begin
		clk_125 = 1'b0;
		forever #50 clk_125 = ~clk_125; // 100 ns period
	end

	initial
	begin
		rst_crc = 1'b1;
		repeat (8) @(posedge clk_125); // 8 cycles in reset
		@(negedge clk_125);
		rst_crc = 1'b0; // released on falling edge
	end

endmodule

//--- test/tb_eth_stream.sv
`timescale 1ns/10ps

module tb_eth_stream;

	logic clk_125;
	logic rst_crc;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_cs_n;
	eth_stream_pkg::sample_in_t ch0;
	eth_stream_pkg::sample_in_t ch1;
	logic [15:0] numb_inter;
	logic time_clr;
	logic tx_rdy;
	eth_stream_pkg::tx_word_t tx;

	// ------------------------------
	// reference model state
	eth_stream_pkg::stream_cfg_t cfg_model; // what the spi writes should have set
	logic [31:0] q0 [$]; // expected samples, channel 0
	logic [31:0] q1 [$];
	logic [15:0] pkt_model; // packet count of next frame
	logic [15:0] numb_model;
	logic turn_model; // channel due next when both hold a block
	eth_stream_pkg::tx_word_t frame_buf [eth_stream_pkg::FRAME_WORDS];
	int beat_idx; // beats of the frame in progress
	int frames_seen;
	logic rdy_random; // 1 puts back-pressure on
	int cycles;

	tb_clock_gen u_clk (.clk_125(clk_125), .rst_crc(rst_crc));

	eth_stream_top uut (
		.clk_125(clk_125), .rst_crc(rst_crc),
		.spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n),
		.ch0(ch0), .ch1(ch1), .numb_inter(numb_inter), .time_clr(time_clr),
		.tx_rdy(tx_rdy), .tx(tx)
	);

	// ------------------------------
	// failure reporting
	task automatic report_mismatch(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input eth_stream_pkg::tx_word_t got,
		input eth_stream_pkg::tx_word_t exp, input int idx);
		if (got !== exp)
			report_mismatch($sformatf("word %0d got %08h sop %b eop %b, expected %08h sop %b eop %b",
				idx, got.data, got.sop, got.eop, exp.data, exp.sop, exp.eop));
	endtask

	task automatic check_desc_fields(input eth_stream_pkg::block_desc_t got,
		input eth_stream_pkg::block_desc_t exp);
		if (got.channel !== exp.channel)
			report_mismatch($sformatf("channel %0d, expected %0d", got.channel, exp.channel));
		if (got.length !== exp.length)
			report_mismatch($sformatf("length %0d, expected %0d", got.length, exp.length));
		if (got.checksum !== exp.checksum)
			report_mismatch($sformatf("checksum %08h, expected %08h", got.checksum, exp.checksum));
		if (got.stamp !== exp.stamp)
			report_mismatch($sformatf("stamp %08h, expected %08h", got.stamp, exp.stamp));
	endtask

	task automatic check_cfg(input eth_stream_pkg::stream_cfg_t got,
		input eth_stream_pkg::stream_cfg_t exp);
		if (got !== exp)
			report_mismatch($sformatf("header config %h, expected %h", got, exp));
	endtask

	// ------------------------------
	// frame checker, runs on each eop
	task automatic check_frame();
		eth_stream_pkg::tx_word_t exp;
		eth_stream_pkg::stream_cfg_t got_cfg;
		eth_stream_pkg::stream_cfg_t exp_cfg;
		eth_stream_pkg::block_desc_t got_desc;
		eth_stream_pkg::block_desc_t exp_desc;
		logic [31:0] payload [eth_stream_pkg::BLOCK_WORDS];
		logic [31:0] hdr [eth_stream_pkg::HDR_WORDS];
		logic [31:0] sum;
		logic [7:0] chan; // channel the model expects
		int n0;
		int n1;
		int i;

		n0 = q0.size();
		n1 = q1.size();
		if (n0 < eth_stream_pkg::BLOCK_WORDS && n1 < eth_stream_pkg::BLOCK_WORDS)
			abort_run("frame sent while neither channel had 16 samples queued");
		// both ready means they take turns
		if (n0 >= eth_stream_pkg::BLOCK_WORDS && n1 >= eth_stream_pkg::BLOCK_WORDS)
			chan = {7'd0, turn_model};
		else if (n1 >= eth_stream_pkg::BLOCK_WORDS)
			chan = 8'd1;
		else
			chan = 8'd0;
		sum = '0;
		for (i = 0; i < eth_stream_pkg::BLOCK_WORDS; i++)
		begin
			if (chan == 8'd0)
				payload[i] = q0.pop_front();
			else
				payload[i] = q1.pop_front();
			sum = sum + payload[i]; // wraps mod 2^32
		end

		hdr[0] = cfg_model.mac_dest[47:16];
		hdr[1] = {cfg_model.mac_dest[15:0], cfg_model.mac_my[47:32]};
		hdr[2] = cfg_model.mac_my[31:0];
		hdr[3] = cfg_model.ip_my;
		hdr[4] = cfg_model.ip_dest;
		hdr[5] = {cfg_model.port_my, cfg_model.port_dest + 16'd1}; // data port
		hdr[6] = {numb_model, pkt_model};
		hdr[7] = {8'd0, chan, 16'(eth_stream_pkg::BLOCK_BYTES)};

		// header fields back into a config
		got_cfg.mac_dest = {frame_buf[0].data, frame_buf[1].data[31:16]};
		got_cfg.mac_my = {frame_buf[1].data[15:0], frame_buf[2].data};
		got_cfg.ip_my = frame_buf[3].data;
		got_cfg.ip_dest = frame_buf[4].data;
		got_cfg.port_my = frame_buf[5].data[31:16];
		got_cfg.port_dest = frame_buf[5].data[15:0];
		got_cfg.stream_off = 1'b0;
		exp_cfg = cfg_model;
		exp_cfg.port_dest = cfg_model.port_dest + 16'd1;
		exp_cfg.stream_off = 1'b0; // frames only while on
		check_cfg(got_cfg, exp_cfg);

		got_desc = '0;
		got_desc.channel = frame_buf[7].data[23:16];
		got_desc.length = frame_buf[7].data[15:0];
		got_desc.checksum = frame_buf[24].data;
		got_desc.stamp = frame_buf[6].data;
		exp_desc = '0;
		exp_desc.channel = chan;
		exp_desc.length = 16'(eth_stream_pkg::BLOCK_BYTES);
		exp_desc.checksum = sum;
		exp_desc.stamp = {numb_model, pkt_model};
		check_desc_fields(got_desc, exp_desc);

		for (i = 0; i < eth_stream_pkg::FRAME_WORDS; i++)
		begin
			exp.wren = 1'b1;
			exp.sop = (i == 0);
			exp.eop = (i == eth_stream_pkg::FRAME_WORDS - 1);
			if (i < eth_stream_pkg::HDR_WORDS)
				exp.data = hdr[i];
			else if (i < eth_stream_pkg::FRAME_WORDS - 1)
				exp.data = payload[i - eth_stream_pkg::HDR_WORDS];
			else
				exp.data = sum; // checksum word
			check_word(frame_buf[i], exp, i);
		end
		pkt_model = pkt_model + 16'd1;
		turn_model = !chan[0]; // other channel next on a tie
	endtask

	// ------------------------------
	// output monitor, beats taken at the rising edge
	always @(posedge clk_125)
	begin
		if (!rst_crc && tx.wren)
		begin
			if (!tx_rdy)
				report_mismatch("beat sent with tx_rdy low");
			if (beat_idx >= eth_stream_pkg::FRAME_WORDS)
				abort_run("frame ran past 25 beats without eop");
			frame_buf[beat_idx] = tx;
			beat_idx = beat_idx + 1;
			if (tx.eop)
			begin
				if (beat_idx != eth_stream_pkg::FRAME_WORDS)
					report_mismatch($sformatf("eop on beat %0d", beat_idx - 1));
				check_frame();
				beat_idx = 0;
				frames_seen = frames_seen + 1;
			end
		end
	end

	always @(negedge clk_125)
	begin
		if (rdy_random)
			tx_rdy = ($urandom_range(3, 0) != 0); // ready three times in four
		else
			tx_rdy = 1'b1;
	end

	// ------------------------------
	// stimulus tasks
	task automatic spi_write(input logic [7:0] addr, input logic [63:0] data);
		logic [71:0] bits;
		int i;

		bits = {addr, data};
		spi_cs_n = 1'b0;
		repeat (3) @(negedge clk_125);
		for (i = 71; i >= 0; i--)
		begin
			spi_mosi = bits[i]; // msb first
			spi_sclk = 1'b0;
			repeat (3) @(negedge clk_125);
			spi_sclk = 1'b1; // sampled on this rise
			repeat (3) @(negedge clk_125);
		end
		spi_sclk = 1'b0;
		repeat (3) @(negedge clk_125);
		spi_cs_n = 1'b1;
		repeat (8) @(negedge clk_125); // field loads within 4 cycles
	endtask

	task automatic write_samples(input int n0, input int n1);
		int c0;
		int c1;
		int guard;

		c0 = 0;
		c1 = 0;
		guard = 0;
		while (c0 < n0 || c1 < n1)
		begin
			@(negedge clk_125);
			ch0.wr = (c0 < n0) && ($urandom_range(1, 0) == 1);
			ch0.data = $urandom;
			ch1.wr = (c1 < n1) && ($urandom_range(1, 0) == 1);
			ch1.data = $urandom;
			if (ch0.wr)
			begin
				q0.push_back(ch0.data);
				c0++;
			end
			if (ch1.wr)
			begin
				q1.push_back(ch1.data);
				c1++;
			end
			guard++;
			if (guard > 10000)
				abort_run("sample writer did not finish");
		end
		@(negedge clk_125);
		ch0.wr = 1'b0;
		ch1.wr = 1'b0;
	endtask

	task automatic wait_frames(input int target, input int limit);
		int n;

		n = 0;
		while (frames_seen < target)
		begin
			@(negedge clk_125);
			n++;
			if (n > limit)
				abort_run($sformatf("timeout waiting for frame %0d, %0d frames arrived",
					target, frames_seen));
		end
	endtask

	// ------------------------------
	// test sequence
	initial
	begin
		void'($urandom(32'h8e197b73)); // seeds this run
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_cs_n = 1'b1;
		ch0 = '0;
		ch1 = '0;
		time_clr = 1'b0;
		tx_rdy = 1'b1;
		rdy_random = 1'b0;
		frames_seen = 0;
		beat_idx = 0;
		pkt_model = '0;
		turn_model = 1'b0; // channel 0 goes first
		numb_model = 16'($urandom);
		numb_inter = numb_model; // held for the whole run
		cfg_model = '0;
		cfg_model.stream_off = 1'b1;

		cycles = 0;
		while (rst_crc !== 1'b0)
		begin
			@(negedge clk_125);
			cycles++;
			if (cycles > 50)
				abort_run("reset was never released");
		end
		@(negedge clk_125);

		// random addresses and ports
		cfg_model.ip_my = $urandom;
		cfg_model.ip_dest = $urandom;
		cfg_model.port_my = 16'($urandom);
		cfg_model.port_dest = 16'($urandom);
		cfg_model.mac_my = {16'($urandom), 32'($urandom)};
		cfg_model.mac_dest = {16'($urandom), 32'($urandom)};
		spi_write(eth_stream_pkg::ADDR_IP, {cfg_model.ip_my, cfg_model.ip_dest});
		spi_write(eth_stream_pkg::ADDR_PORT,
			{32'($urandom), cfg_model.port_my, cfg_model.port_dest}); // upper half ignored
		spi_write(eth_stream_pkg::ADDR_MAC_MY, {16'($urandom), cfg_model.mac_my});
		spi_write(eth_stream_pkg::ADDR_MAC_DEST, {16'($urandom), cfg_model.mac_dest});
		spi_write(eth_stream_pkg::ADDR_CONTROL, 64'd0);
		cfg_model.stream_off = 1'b0;

		// both channels, tx_rdy held high
		write_samples(48, 48);
		wait_frames(6, 5000);

		// count restarts at zero
		@(negedge clk_125);
		time_clr = 1'b1;
		@(negedge clk_125);
		time_clr = 1'b0;
		pkt_model = '0;

		// back-pressure
		rdy_random = 1'b1;
		write_samples(32, 32);
		wait_frames(10, 8000);
		rdy_random = 1'b0;

		// stream off drops samples
		spi_write(eth_stream_pkg::ADDR_CONTROL, 64'd1);
		cfg_model.stream_off = 1'b1;
		write_samples(20, 20);
		q0.delete();
		q1.delete();
		for (cycles = 0; cycles < 300; cycles++)
		begin
			@(negedge clk_125);
			if (frames_seen != 10 || beat_idx != 0)
				abort_run("a frame was sent while the stream was off");
		end
		spi_write(eth_stream_pkg::ADDR_CONTROL, 64'd0);
		cfg_model.stream_off = 1'b0;
		write_samples(32, 32);
		wait_frames(14, 5000);

		repeat (4) @(negedge clk_125);
		if (q0.size() != 0 || q1.size() != 0 || beat_idx != 0)
			abort_run($sformatf("run ended with %0d and %0d samples never sent",
				q0.size(), q1.size()));
		else
		begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

//--- build.f
hdl/eth_stream_pkg.sv
hdl/spi_config_regs.sv
hdl/channel_fifo.sv
hdl/block_assembler.sv
hdl/stream_framer.sv
hdl/eth_stream_top.sv
test/tb_clock_gen.sv
test/tb_eth_stream.sv
